// File: hdl/sysmap_types_pkg.sv
// ========================================
// System map types
// Widths and vector types for region base
// addresses, flags, pad attributes and the
// peripheral bus fields
// ========================================

`default_nettype none

package sysmap_types_pkg;

  // Base register holds address bits 31:12
  localparam int base_width = 20;
  localparam int flag_width = 5;
  localparam int attr_width = 3;

  // Peripheral bus fields
  localparam int bus_addr_width = 16;
  localparam int bus_data_width = 32;

  typedef logic [base_width-1:0]     base_addr_t;
  typedef logic [flag_width-1:0]     flag_t;
  typedef logic [attr_width-1:0]     attr_t;
  typedef logic [bus_addr_width-1:0] bus_addr_t;
  typedef logic [bus_data_width-1:0] bus_data_t;

endpackage

`default_nettype wire

// File: hdl/sysmap_regmap_pkg.sv
// ========================================
// System map register layout
// Region stride, flag offset, decoded
// address width and default region count
// ========================================

`default_nettype none

package sysmap_regmap_pkg;

  // Byte distance between two regions
  localparam int region_stride = 8;

  // Flag register sits one word above the base register
  localparam int flag_offset = 4;

  // Only address bits 11:0 take part in decoding
  localparam int decode_bits = 12;

  localparam int default_region_count = 8;

  // Low bits select the register inside a region
  localparam int stride_bits = $clog2(region_stride);

  // Remaining decoded bits give the region index for up to 512 regions
  localparam int index_bits = decode_bits - stride_bits;

endpackage

`default_nettype wire

// File: hdl/sysmap_base_bank.sv
// ========================================
// System map base address bank
// One base register per region, loaded
// from pad defaults or by bus writes
// ========================================

`timescale 1ns/1ps
`default_nettype none

module sysmap_base_bank #(
  parameter int region_count = sysmap_regmap_pkg::default_region_count
) (
  input  wire                                            forever_cpuclk,
  input  wire                                            reset,
  input  wire                                            sel,
  input  wire                                            write,
  input  wire sysmap_types_pkg::bus_addr_t               addr,
  input  wire sysmap_types_pkg::bus_data_t               wdata,
  input  wire                                            rst_sample,
  input  wire sysmap_types_pkg::base_addr_t [region_count-1:0] pad_base,
  output sysmap_types_pkg::base_addr_t [region_count-1:0]     base_values
);

  localparam int stride_w = sysmap_regmap_pkg::stride_bits;
  localparam int index_w  = sysmap_regmap_pkg::index_bits;
  localparam int decode_w = sysmap_regmap_pkg::decode_bits;
  localparam int base_w   = sysmap_types_pkg::base_width;

  logic                   bus_wr;
  logic [index_w-1:0]     addr_index;
  logic [stride_w-1:0]    addr_offset;
  logic                   base_slot;
  logic [region_count-1:0] wr_hit;

  sysmap_types_pkg::base_addr_t [region_count-1:0] base_q;

  assign bus_wr = sel & write;

  // Split decoded bits into region index and in-region offset
  assign addr_index  = addr[decode_w-1:stride_w];
  assign addr_offset = addr[stride_w-1:0];

  // Base register is the first word of each region
  assign base_slot = (addr_offset == '0);

  for (genvar i = 0; i < region_count; i++)
  begin : g_region
    assign wr_hit[i] = bus_wr && base_slot && (addr_index == index_w'(i));

    // Pad sample wins over a bus write in the same cycle
    always_ff @(posedge forever_cpuclk)
    begin
      if (reset)
      begin
        base_q[i] <= '0;
      end
      else if (rst_sample)
      begin
        base_q[i] <= pad_base[i];
      end
      else if (wr_hit[i])
      begin
        base_q[i] <= wdata[base_w-1:0];
      end
    end
  end

  assign base_values = base_q;

endmodule

`default_nettype wire

// File: hdl/sysmap_flag_bank.sv
// ========================================
// System map flag bank
// One flag register per region, loaded
// from pad attributes or by bus writes
// ========================================

`timescale 1ns/1ps
`default_nettype none

module sysmap_flag_bank #(
  parameter int region_count = sysmap_regmap_pkg::default_region_count
) (
  input  wire                                          forever_cpuclk,
  input  wire                                          reset,
  input  wire                                          sel,
  input  wire                                          write,
  input  wire sysmap_types_pkg::bus_addr_t             addr,
  input  wire sysmap_types_pkg::bus_data_t             wdata,
  input  wire                                          rst_sample,
  input  wire sysmap_types_pkg::attr_t [region_count-1:0] pad_attr,
  output sysmap_types_pkg::flag_t [region_count-1:0]      flag_values
);

  localparam int stride_w = sysmap_regmap_pkg::stride_bits;
  localparam int index_w  = sysmap_regmap_pkg::index_bits;
  localparam int decode_w = sysmap_regmap_pkg::decode_bits;
  localparam int flag_w   = sysmap_types_pkg::flag_width;

  logic                    bus_wr;
  logic [index_w-1:0]      addr_index;
  logic [stride_w-1:0]     addr_offset;
  logic                    flag_slot;
  logic [region_count-1:0] wr_hit;

  sysmap_types_pkg::flag_t [region_count-1:0] flag_q;

  assign bus_wr = sel & write;

  assign addr_index  = addr[decode_w-1:stride_w];
  assign addr_offset = addr[stride_w-1:0];

  // Flag register is the second word of each region
  assign flag_slot = (addr_offset == stride_w'(sysmap_regmap_pkg::flag_offset));

  for (genvar i = 0; i < region_count; i++)
  begin : g_region
    assign wr_hit[i] = bus_wr && flag_slot && (addr_index == index_w'(i));

    // Pad attribute lands in the low bits with upper flag bits cleared
    always_ff @(posedge forever_cpuclk)
    begin
      if (reset)
      begin
        flag_q[i] <= '0;
      end
      else if (rst_sample)
      begin
        flag_q[i] <= sysmap_types_pkg::flag_t'(pad_attr[i]);
      end
      else if (wr_hit[i])
      begin
        flag_q[i] <= wdata[flag_w-1:0];
      end
    end
  end

  assign flag_values = flag_q;

endmodule

`default_nettype wire

// File: hdl/sysmap_read_mux.sv
// ========================================
// System map read mux
// Picks the addressed base or flag value
// and zero-extends it onto the read data
// ========================================

`timescale 1ns/1ps
`default_nettype none

module sysmap_read_mux #(
  parameter int region_count = sysmap_regmap_pkg::default_region_count
) (
  input  wire sysmap_types_pkg::bus_addr_t                    addr,
  input  wire sysmap_types_pkg::base_addr_t [region_count-1:0] base_values,
  input  wire sysmap_types_pkg::flag_t [region_count-1:0]      flag_values,
  output sysmap_types_pkg::bus_data_t                          rdata
);

  localparam int stride_w = sysmap_regmap_pkg::stride_bits;
  localparam int index_w  = sysmap_regmap_pkg::index_bits;
  localparam int decode_w = sysmap_regmap_pkg::decode_bits;

  logic [index_w-1:0]  addr_index;
  logic [stride_w-1:0] addr_offset;
  logic                index_valid;

  assign addr_index  = addr[decode_w-1:stride_w];
  assign addr_offset = addr[stride_w-1:0];

  // Indices past the last region read as zero
  assign index_valid = (32'(addr_index) < region_count);

  always_comb
  begin
    rdata = '0;
    if (index_valid)
    begin
      if (addr_offset == '0)
      begin
        rdata = sysmap_types_pkg::bus_data_t'(base_values[addr_index]);
      end
      else if (addr_offset == stride_w'(sysmap_regmap_pkg::flag_offset))
      begin
        rdata = sysmap_types_pkg::bus_data_t'(flag_values[addr_index]);
      end
      // Misaligned or reserved offsets fall through to zero
    end
  end

endmodule

`default_nettype wire

// File: hdl/sysmap_busif.sv
// ========================================
// System map bus interface
// Top of the region register block: base
// and flag banks, read mux and completion
// ========================================

`timescale 1ns/1ps
`default_nettype none

module sysmap_busif #(
  parameter int region_count = sysmap_regmap_pkg::default_region_count
) (
  input  wire                                                  forever_cpuclk,
  input  wire                                                  reset,

  // Peripheral bus request
  input  wire                                                  sysmap_sel,
  input  wire                                                  sysmap_write,
  input  wire sysmap_types_pkg::bus_addr_t                     sysmap_addr,
  input  wire sysmap_types_pkg::bus_data_t                     sysmap_wdata,

  // Pad defaults and their sample pulse
  input  wire                                                  sysmap_rst_sample,
  input  wire sysmap_types_pkg::base_addr_t [region_count-1:0] pad_sysmap_base,
  input  wire sysmap_types_pkg::attr_t [region_count-1:0]      pad_sysmap_attr,

  // Bus response
  output logic                                                 sysmap_cmplt,
  output sysmap_types_pkg::bus_data_t                          sysmap_rdata,

  // Current region settings
  output sysmap_types_pkg::base_addr_t [region_count-1:0]      sysmap_base_values,
  output sysmap_types_pkg::flag_t [region_count-1:0]           sysmap_flag_values
);

  // Every request finishes in the cycle it is presented
  assign sysmap_cmplt = sysmap_sel;

  sysmap_base_bank #(
    .region_count (region_count)
  ) base_bank_inst (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .sel            (sysmap_sel),
    .write          (sysmap_write),
    .addr           (sysmap_addr),
    .wdata          (sysmap_wdata),
    .rst_sample     (sysmap_rst_sample),
    .pad_base       (pad_sysmap_base),
    .base_values    (sysmap_base_values)
  );

  sysmap_flag_bank #(
    .region_count (region_count)
  ) flag_bank_inst (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .sel            (sysmap_sel),
    .write          (sysmap_write),
    .addr           (sysmap_addr),
    .wdata          (sysmap_wdata),
    .rst_sample     (sysmap_rst_sample),
    .pad_attr       (pad_sysmap_attr),
    .flag_values    (sysmap_flag_values)
  );

  // Read data is combinational and valid alongside completion
  sysmap_read_mux #(
    .region_count (region_count)
  ) read_mux_inst (
    .addr        (sysmap_addr),
    .base_values (sysmap_base_values),
    .flag_values (sysmap_flag_values),
    .rdata       (sysmap_rdata)
  );

endmodule

`default_nettype wire

// File: test/sysmap_busif_checker.sv
// ========================================
// System map bus checker
// Concurrent rules on completion, reset
// state and unmapped reads, bound to the
// register block top level
// ========================================

`timescale 1ns/1ps
`default_nettype none

module sysmap_busif_checker #(
  parameter int region_count = sysmap_regmap_pkg::default_region_count
) (
  input wire                                                  forever_cpuclk,
  input wire                                                  reset,
  input wire                                                  sysmap_sel,
  input wire                                                  sysmap_write,
  input wire                                                  sysmap_cmplt,
  input wire sysmap_types_pkg::bus_addr_t                     sysmap_addr,
  input wire sysmap_types_pkg::bus_data_t                     sysmap_rdata,
  input wire sysmap_types_pkg::base_addr_t [region_count-1:0] sysmap_base_values,
  input wire sysmap_types_pkg::flag_t [region_count-1:0]      sysmap_flag_values
);

  localparam int decode_w     = sysmap_regmap_pkg::decode_bits;
  localparam int mapped_bytes = region_count * sysmap_regmap_pkg::region_stride;

  int unsigned violation_count = 0;

  logic unmapped_read;

  // Read request past the last region
  assign unmapped_read = sysmap_sel && !sysmap_write
                         && (32'(sysmap_addr[decode_w-1:0]) >= 32'(mapped_bytes));

  cmplt_follows_sel: assert property (@(posedge forever_cpuclk) sysmap_cmplt == sysmap_sel)
  else
  begin
    violation_count++;
    $error("completion strobe differs from select");
  end

  regs_clear_after_reset: assert property (@(posedge forever_cpuclk)
    reset |=> (sysmap_base_values == '0) && (sysmap_flag_values == '0))
  else
  begin
    violation_count++;
    $error("region outputs not zero in the cycle after reset");
  end

  unmapped_reads_zero: assert property (@(posedge forever_cpuclk)
    unmapped_read |-> (sysmap_rdata == '0))
  else
  begin
    violation_count++;
    $error("read beyond the last region returned nonzero data");
  end

endmodule

bind sysmap_busif sysmap_busif_checker #(
  .region_count (region_count)
) busif_checker_inst (
  .forever_cpuclk     (forever_cpuclk),
  .reset              (reset),
  .sysmap_sel         (sysmap_sel),
  .sysmap_write       (sysmap_write),
  .sysmap_cmplt       (sysmap_cmplt),
  .sysmap_addr        (sysmap_addr),
  .sysmap_rdata       (sysmap_rdata),
  .sysmap_base_values (sysmap_base_values),
  .sysmap_flag_values (sysmap_flag_values)
);

`default_nettype wire

// File: test/sysmap_busif_tb.sv
// ========================================
// System map register block testbench
// Directed tests of reset, pad sampling,
// register writes, select gating, unmapped
// offsets and sample priority
// ========================================

`timescale 1ns/1ps
`default_nettype none

module sysmap_busif_tb;

  localparam int region_count = sysmap_regmap_pkg::default_region_count;
  localparam int stride       = sysmap_regmap_pkg::region_stride;
  localparam int flag_off     = sysmap_regmap_pkg::flag_offset;
  localparam int decode_w     = sysmap_regmap_pkg::decode_bits;

  // Watchdog allows twice the rough cycle budget of all tests
  localparam int test_cycles = 12 * region_count + 80;
  localparam int timeout_ns  = 2 * test_cycles * 20;

  logic                                            forever_cpuclk;
  logic                                            reset;
  logic                                            sysmap_sel;
  logic                                            sysmap_write;
  sysmap_types_pkg::bus_addr_t                     sysmap_addr;
  sysmap_types_pkg::bus_data_t                     sysmap_wdata;
  logic                                            sysmap_rst_sample;
  sysmap_types_pkg::base_addr_t [region_count-1:0] pad_sysmap_base;
  sysmap_types_pkg::attr_t [region_count-1:0]      pad_sysmap_attr;
  logic                                            sysmap_cmplt;
  sysmap_types_pkg::bus_data_t                     sysmap_rdata;
  sysmap_types_pkg::base_addr_t [region_count-1:0] sysmap_base_values;
  sysmap_types_pkg::flag_t [region_count-1:0]      sysmap_flag_values;

  // Expected register contents
  sysmap_types_pkg::base_addr_t exp_base [region_count];
  sysmap_types_pkg::flag_t      exp_flag [region_count];

  logic [15:0] lfsr_state;
  int          error_count;
  int          tests_run;
  int          tests_failed;

  sysmap_busif #(
    .region_count (region_count)
  ) sysmap_busif_inst (
    .forever_cpuclk     (forever_cpuclk),
    .reset              (reset),
    .sysmap_sel         (sysmap_sel),
    .sysmap_write       (sysmap_write),
    .sysmap_addr        (sysmap_addr),
    .sysmap_wdata       (sysmap_wdata),
    .sysmap_rst_sample  (sysmap_rst_sample),
    .pad_sysmap_base    (pad_sysmap_base),
    .pad_sysmap_attr    (pad_sysmap_attr),
    .sysmap_cmplt       (sysmap_cmplt),
    .sysmap_rdata       (sysmap_rdata),
    .sysmap_base_values (sysmap_base_values),
    .sysmap_flag_values (sysmap_flag_values)
  );

  always #10 forever_cpuclk = ~forever_cpuclk;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic sysmap_types_pkg::bus_addr_t base_addr_of(input int region);
    return sysmap_types_pkg::bus_addr_t'(region * stride);
  endfunction

  function automatic sysmap_types_pkg::bus_addr_t flag_addr_of(input int region);
    return sysmap_types_pkg::bus_addr_t'(region * stride + flag_off);
  endfunction

  // Read value from the register map rules
  function automatic sysmap_types_pkg::bus_data_t expected_read(
    input sysmap_types_pkg::bus_addr_t addr
  );
    int offset;
    int region;
    int slot;
    offset = 32'(addr[decode_w-1:0]);
    region = offset / stride;
    slot   = offset % stride;
    if (region >= region_count)
      return '0;
    if (slot == 0)
      return 32'(exp_base[region]);
    if (slot == flag_off)
      return 32'(exp_flag[region]);
    return '0;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected)
    else
    begin
      $display("CHECK FAILED at %0t: %s is 0x%08h, expected 0x%08h",
               $time, what, got, expected);
      error_count++;
    end
  endtask

  task automatic check_outputs();
    for (int i = 0; i < region_count; i++)
    begin
      check_value($sformatf("base output %0d", i), 32'(sysmap_base_values[i]),
                  32'(exp_base[i]));
      check_value($sformatf("flag output %0d", i), 32'(sysmap_flag_values[i]),
                  32'(exp_flag[i]));
    end
  endtask

  task automatic bus_write(input sysmap_types_pkg::bus_addr_t addr,
                           input sysmap_types_pkg::bus_data_t data);
    sysmap_sel   = 1'b1;
    sysmap_write = 1'b1;
    sysmap_addr  = addr;
    sysmap_wdata = data;
    #1;
    check_value("completion on write", 32'(sysmap_cmplt), 32'(1));
    @(posedge forever_cpuclk);
    #2;
    sysmap_sel   = 1'b0;
    sysmap_write = 1'b0;
  endtask

  task automatic read_and_check(input sysmap_types_pkg::bus_addr_t addr);
    sysmap_sel   = 1'b1;
    sysmap_write = 1'b0;
    sysmap_addr  = addr;
    #1;
    check_value("completion on read", 32'(sysmap_cmplt), 32'(1));
    check_value($sformatf("read of 0x%04h", addr), sysmap_rdata, expected_read(addr));
    @(posedge forever_cpuclk);
    #2;
    sysmap_sel = 1'b0;
  endtask

  task automatic read_all_regions();
    for (int i = 0; i < region_count; i++)
    begin
      read_and_check(base_addr_of(i));
      read_and_check(flag_addr_of(i));
    end
  endtask

  // Pad sample pulse with an optional bus write
  task automatic sample_pads(input logic with_write,
                             input sysmap_types_pkg::bus_addr_t addr,
                             input sysmap_types_pkg::bus_data_t data);
    sysmap_rst_sample = 1'b1;
    sysmap_sel        = with_write;
    sysmap_write      = with_write;
    sysmap_addr       = addr;
    sysmap_wdata      = data;
    @(posedge forever_cpuclk);
    #2;
    sysmap_rst_sample = 1'b0;
    sysmap_sel        = 1'b0;
    sysmap_write      = 1'b0;
    for (int i = 0; i < region_count; i++)
    begin
      exp_base[i] = pad_sysmap_base[i];
      exp_flag[i] = sysmap_types_pkg::flag_t'(pad_sysmap_attr[i]);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests_run++;
    if (error_count == start_errors)
      $display("%s: passed", name);
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - start_errors);
    end
  endtask

  task automatic test_reset_values();
    int start;
    start = error_count;
    check_outputs();
    read_all_regions();
    report_test("reset values", start);
  endtask

  task automatic test_pad_sample();
    int start;
    start = error_count;
    sample_pads(1'b0, '0, '0);
    check_outputs();
    read_all_regions();
    report_test("pad sample", start);
  endtask

  task automatic test_register_writes();
    int start;
    sysmap_types_pkg::bus_data_t data;
    start = error_count;
    for (int i = 0; i < region_count; i++)
    begin
      data = take_bits(32);
      bus_write(base_addr_of(i), data);
      exp_base[i] = sysmap_types_pkg::base_addr_t'(data);
      check_outputs();
      read_and_check(base_addr_of(i));
      data = take_bits(32);
      bus_write(flag_addr_of(i), data);
      exp_flag[i] = sysmap_types_pkg::flag_t'(data);
      check_outputs();
      read_and_check(flag_addr_of(i));
    end
    report_test("register writes", start);
  endtask

  task automatic test_select_gating();
    int start;
    start = error_count;
    // Let the select release settle before looking at completion
    #1;
    check_value("completion while idle", 32'(sysmap_cmplt), 32'(0));
    @(posedge forever_cpuclk);
    #2;
    // Write strobe without select must be ignored
    sysmap_write = 1'b1;
    sysmap_addr  = base_addr_of(1);
    sysmap_wdata = take_bits(32);
    #1;
    check_value("completion with select low", 32'(sysmap_cmplt), 32'(0));
    @(posedge forever_cpuclk);
    #2;
    sysmap_addr  = flag_addr_of(1);
    sysmap_wdata = take_bits(32);
    @(posedge forever_cpuclk);
    #2;
    sysmap_write = 1'b0;
    check_outputs();
    read_and_check(base_addr_of(1));
    read_and_check(flag_addr_of(1));
    report_test("select gating", start);
  endtask

  task automatic probe_unmapped(input sysmap_types_pkg::bus_addr_t addr);
    read_and_check(addr);
    bus_write(addr, take_bits(32));
    check_outputs();
    read_and_check(addr);
  endtask

  task automatic test_unmapped_offsets();
    int start;
    start = error_count;
    probe_unmapped(sysmap_types_pkg::bus_addr_t'(region_count * stride));
    probe_unmapped(sysmap_types_pkg::bus_addr_t'(region_count * stride + flag_off));
    probe_unmapped(16'h0ffc);
    probe_unmapped(16'h0800);
    // Misaligned offsets inside mapped regions
    probe_unmapped(16'h0001);
    probe_unmapped(16'h0002);
    probe_unmapped(16'h0003);
    probe_unmapped(16'h0005);
    probe_unmapped(16'h0006);
    probe_unmapped(16'h0007);
    probe_unmapped(base_addr_of(3) + 16'h0002);
    probe_unmapped(flag_addr_of(5) + 16'h0003);
    report_test("unmapped offsets", start);
  endtask

  task automatic test_sample_priority();
    int start;
    sysmap_types_pkg::bus_data_t data;
    start = error_count;
    data = take_bits(32);
    bus_write(base_addr_of(2), data);
    exp_base[2] = sysmap_types_pkg::base_addr_t'(data);
    sample_pads(1'b1, base_addr_of(2), take_bits(32));
    check_outputs();
    read_and_check(base_addr_of(2));
    data = take_bits(32);
    bus_write(flag_addr_of(3), data);
    exp_flag[3] = sysmap_types_pkg::flag_t'(data);
    sample_pads(1'b1, flag_addr_of(3), take_bits(32));
    check_outputs();
    read_all_regions();
    report_test("sample priority", start);
  endtask

  initial
  begin
    #(timeout_ns);
    $display("Timeout: tests did not finish within %0d ns", timeout_ns);
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    forever_cpuclk    = 1'b0;
    reset             = 1'b1;
    sysmap_sel        = 1'b0;
    sysmap_write      = 1'b0;
    sysmap_addr       = '0;
    sysmap_wdata      = '0;
    sysmap_rst_sample = 1'b0;
    lfsr_state        = 16'd58667;
    error_count       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    for (int i = 0; i < region_count; i++)
    begin
      pad_sysmap_base[i] = sysmap_types_pkg::base_addr_t'(take_bits(20));
      pad_sysmap_attr[i] = sysmap_types_pkg::attr_t'(take_bits(3));
      exp_base[i]        = '0;
      exp_flag[i]        = '0;
    end
    repeat (3) @(posedge forever_cpuclk);
    #2;
    reset = 1'b0;

    test_reset_values();
    test_pad_sample();
    test_register_writes();
    test_select_gating();
    test_unmapped_offsets();
    test_sample_priority();

    $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, error_count,
             sysmap_busif_inst.busif_checker_inst.violation_count);
    if (error_count == 0 && sysmap_busif_inst.busif_checker_inst.violation_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hdl/sysmap_types_pkg.sv
hdl/sysmap_regmap_pkg.sv
hdl/sysmap_base_bank.sv
hdl/sysmap_flag_bank.sv
hdl/sysmap_read_mux.sv
hdl/sysmap_busif.sv
test/sysmap_busif_checker.sv
test/sysmap_busif_tb.sv

// File: Makefile
# Verilator build for the system map register block

VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := sysmap_busif_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
